// ==== hw/rp_analog_pkg.sv ====
// analog datapath package
// widths, register map and the struct types shared by the datapath and the register block
`default_nettype none

package rp_analog_pkg;

  ////////////////////
  // datapath sizes
  ////////////////////

  localparam int unsigned N_CH  = 2;   // analog channels
  localparam int unsigned ADC_W = 16;  // adc sample width
  localparam int unsigned DAC_W = 14;  // dac sample width

  ////////////////////
  // axi4-lite and register map
  ////////////////////

  localparam int unsigned AXI_AW = 8;
  localparam int unsigned AXI_DW = 32;

  localparam logic [AXI_DW-1:0] ID_VALUE    = 32'h52500A01;
  localparam logic [AXI_AW-1:0] REG_ID      = 8'h00;  // read only
  localparam logic [AXI_AW-1:0] REG_LOOP    = 8'h04;  // bit 0 adc loop, bit 1 dac loop
  localparam logic [AXI_AW-1:0] REG_CH_BASE = 8'h10;  // one word per channel
  localparam int unsigned       CH_FB_BIT   = 16;     // feedback enable in channel word

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // sample types
  typedef logic signed [ADC_W-1:0] adc_sample_t;
  typedef logic signed [DAC_W-1:0] dac_sample_t;

  typedef struct packed {
    dac_sample_t level;  // dc level of the generator
    logic        fb_en;  // pass adc sample into the mix
  } chan_cfg_t;

  typedef struct packed {
    logic dac_loop;  // adc lane straight onto dac pins
    logic adc_loop;  // mix result back into the front end
  } loop_cfg_t;

  // master driven half of the bus
  typedef struct packed {
    logic                  awvalid;
    logic [AXI_AW-1:0]     awaddr;
    logic                  wvalid;
    logic [AXI_DW-1:0]     wdata;
    logic [AXI_DW/8-1:0]   wstrb;
    logic                  bready;
    logic                  arvalid;
    logic [AXI_AW-1:0]     araddr;
    logic                  rready;
  } axil_req_t;

  // slave driven half
  typedef struct packed {
    logic                  awready;
    logic                  wready;
    logic                  bvalid;
    logic [1:0]            bresp;
    logic                  arready;
    logic                  rvalid;
    logic [AXI_DW-1:0]     rdata;
    logic [1:0]            rresp;
  } axil_rsp_t;

endpackage : rp_analog_pkg

`default_nettype wire

// ==== hw/adc_frontend.sv ====
// adc front end
// converts raw negative-slope lanes to two's complement, with the adc-side digital loop
`timescale 1ns/1ps
`default_nettype none

module adc_frontend
  import rp_analog_pkg::*;
(
  input  wire logic                         adc_clk,
  input  wire logic                         rst_n_i,
  input  wire logic [N_CH-1:0][ADC_W-1:0]   adc_raw_i,   // raw lanes from the adc
  input  wire loop_cfg_t                    loop_i,
  input  wire dac_sample_t [N_CH-1:0]       mix_i,       // registered mix results
  output adc_sample_t [N_CH-1:0]            adc_conv_o,  // converted lanes
  output adc_sample_t [N_CH-1:0]            adc_dat_o    // sample seen by the mixers
);

  adc_sample_t [N_CH-1:0] conv;      // lane after conversion
  adc_sample_t [N_CH-1:0] loop_dat;  // mix scaled up to adc width
  adc_sample_t [N_CH-1:0] conv_q;
  adc_sample_t [N_CH-1:0] dat_q;

  ////////////////////
  // conversion
  ////////////////////

  always_comb begin
    for (int ch = 0; ch < N_CH; ch++) begin
      // msb kept, lower bits flipped
      conv[ch]     = {adc_raw_i[ch][ADC_W-1], ~adc_raw_i[ch][ADC_W-2:0]};
      loop_dat[ch] = {mix_i[ch], 2'b00};  // times four
    end
  end

  ////////////////////
  // input register
  ////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      conv_q <= '0;
      dat_q  <= '0;
    end else begin
      conv_q <= conv;
      for (int ch = 0; ch < N_CH; ch++) begin
        dat_q[ch] <= loop_i.adc_loop ? loop_dat[ch] : conv[ch];  // digital loop select
      end
    end
  end

  assign adc_conv_o = conv_q;
  assign adc_dat_o  = dat_q;

endmodule : adc_frontend

`default_nettype wire

// ==== hw/dac_chan_mix.sv ====
// dac channel mixer
// adds the dc level to the feedback term and saturates to the dac range
`timescale 1ns/1ps
`default_nettype none

module dac_chan_mix
  import rp_analog_pkg::*;
(
  input  wire logic        adc_clk,
  input  wire logic        rst_n_i,
  input  wire chan_cfg_t   cfg_i,
  input  wire adc_sample_t adc_dat_i,  // front end sample
  output dac_sample_t      mix_o
);

  dac_sample_t            fb_term;  // feedback part
  logic signed [DAC_W:0]  sum;      // one bit headroom
  dac_sample_t            sat;
  dac_sample_t            mix_q;

  always_comb begin
    // upper bits of the sample, or nothing
    fb_term = cfg_i.fb_en ? adc_dat_i[ADC_W-1 -: DAC_W] : '0;
    sum     = {cfg_i.level[DAC_W-1], cfg_i.level} + {fb_term[DAC_W-1], fb_term};
    if (sum[DAC_W] ^ sum[DAC_W-1]) begin
      sat = {sum[DAC_W], {(DAC_W-1){~sum[DAC_W]}}};  // clamp to 8191 or -8192
    end else begin
      sat = sum[DAC_W-1:0];
    end
  end

  // mix register
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mix_q <= '0;
    end else begin
      mix_q <= sat;
    end
  end

  assign mix_o = mix_q;

endmodule : dac_chan_mix

`default_nettype wire

// ==== hw/dac_formatter.sv ====
// dac output formatter
// signed samples to negative-slope offset code, dac-side loop in the output register
`timescale 1ns/1ps
`default_nettype none

module dac_formatter
  import rp_analog_pkg::*;
(
  input  wire logic                       adc_clk,
  input  wire logic                       rst_n_i,
  input  wire loop_cfg_t                  loop_i,
  input  wire dac_sample_t [N_CH-1:0]     mix_i,       // saturated channel results
  input  wire adc_sample_t [N_CH-1:0]     adc_conv_i,  // converted adc lanes
  output logic [N_CH-1:0][DAC_W-1:0]      dac_code_o   // to the dac pins
);

  // code of sample zero
  localparam logic [DAC_W-1:0] CODE_ZERO = {1'b0, {(DAC_W-1){1'b1}}};

  logic [N_CH-1:0][DAC_W-1:0] code;   // converted mix
  logic [N_CH-1:0][DAC_W-1:0] code_q;

  always_comb begin
    for (int ch = 0; ch < N_CH; ch++) begin
      // msb kept, lower 13 bits flipped
      code[ch] = {mix_i[ch][DAC_W-1], ~mix_i[ch][DAC_W-2:0]};
    end
  end

  ////////////////////
  // output register
  ////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      code_q <= {N_CH{CODE_ZERO}};
    end else begin
      for (int ch = 0; ch < N_CH; ch++) begin
        if (loop_i.dac_loop) begin
          code_q[ch] <= adc_conv_i[ch][ADC_W-1 -: DAC_W];  // no code conversion here
        end else begin
          code_q[ch] <= code[ch];
        end
      end
    end
  end

  assign dac_code_o = code_q;

endmodule : dac_formatter

`default_nettype wire

// ==== hw/housekeeping_regs.sv ====
// housekeeping register block
// axi4-lite slave with id, loopback and per channel level and feedback registers
`timescale 1ns/1ps
`default_nettype none

module housekeeping_regs
  import rp_analog_pkg::*;
(
  input  wire logic          adc_clk,
  input  wire logic          rst_n_i,
  input  wire axil_req_t     axil_req_i,
  output axil_rsp_t          axil_rsp_o,
  output loop_cfg_t          loop_o,
  output chan_cfg_t [N_CH-1:0] chan_cfg_o
);

  logic                        wr_acc;       // write handshake this cycle
  logic                        rd_acc;       // read handshake this cycle
  logic [N_CH-1:0]             wr_ch_sel;
  logic                        wr_hit;
  logic                        rd_hit;
  logic [AXI_DW-1:0]           loop_wr_word; // loop word after strobes
  logic [N_CH-1:0][AXI_DW-1:0] ch_wr_word;

  logic                        bvalid_q;
  logic                        rvalid_q;
  logic [1:0]                  bresp_q;
  logic [1:0]                  rresp_q;
  logic [AXI_DW-1:0]           rdata_q;

  loop_cfg_t                   loop_q;
  chan_cfg_t [N_CH-1:0]        chan_cfg_q;

  ////////////////////
  // helpers
  ////////////////////

  function automatic logic [AXI_DW-1:0] loop_word(input loop_cfg_t l);
    return {{(AXI_DW-2){1'b0}}, l.dac_loop, l.adc_loop};
  endfunction

  // level in the low bits, not sign extended
  function automatic logic [AXI_DW-1:0] ch_word(input chan_cfg_t c);
    logic [AXI_DW-1:0] w;
    w                = '0;
    w[DAC_W-1:0]     = c.level;
    w[CH_FB_BIT]     = c.fb_en;
    return w;
  endfunction

  function automatic logic [AXI_DW-1:0] merge_strb(input logic [AXI_DW-1:0]   old_w,
                                                   input logic [AXI_DW-1:0]   new_w,
                                                   input logic [AXI_DW/8-1:0] strb);
    logic [AXI_DW-1:0] w;
    w = old_w;
    for (int b = 0; b < AXI_DW/8; b++) begin
      if (strb[b]) w[8*b +: 8] = new_w[8*b +: 8];
    end
    return w;
  endfunction

  function automatic logic [N_CH-1:0] ch_sel(input logic [AXI_AW-1:0] addr);
    logic [N_CH-1:0] sel;
    sel = '0;
    for (int n = 0; n < N_CH; n++) begin
      sel[n] = (addr == AXI_AW'(REG_CH_BASE + 4*n));
    end
    return sel;
  endfunction

  function automatic logic is_mapped(input logic [AXI_AW-1:0] addr);
    return (addr == REG_ID) || (addr == REG_LOOP) || (|ch_sel(addr));
  endfunction

  // read mux, zero outside the map
  function automatic logic [AXI_DW-1:0] rd_word(input logic [AXI_AW-1:0] addr);
    logic [AXI_DW-1:0] w;
    logic [N_CH-1:0]   sel;
    w   = '0;
    sel = ch_sel(addr);
    if (addr == REG_ID)   w = ID_VALUE;
    if (addr == REG_LOOP) w = loop_word(loop_q);
    for (int n = 0; n < N_CH; n++) begin
      if (sel[n]) w = ch_word(chan_cfg_q[n]);
    end
    return w;
  endfunction

  ////////////////////
  // decode
  ////////////////////

  assign wr_acc    = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_q;  // aw and w together
  assign rd_acc    = axil_req_i.arvalid & ~rvalid_q;
  assign wr_ch_sel = ch_sel(axil_req_i.awaddr);
  assign wr_hit    = is_mapped(axil_req_i.awaddr);
  assign rd_hit    = is_mapped(axil_req_i.araddr);

  always_comb begin
    loop_wr_word = merge_strb(loop_word(loop_q), axil_req_i.wdata, axil_req_i.wstrb);
    for (int n = 0; n < N_CH; n++) begin
      ch_wr_word[n] = merge_strb(ch_word(chan_cfg_q[n]), axil_req_i.wdata, axil_req_i.wstrb);
    end
  end

  ////////////////////
  // config registers
  ////////////////////

  // updated on the edge where bvalid rises
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      loop_q     <= '0;
      chan_cfg_q <= '0;
    end else if (wr_acc) begin
      if (axil_req_i.awaddr == REG_LOOP) begin
        loop_q.adc_loop <= loop_wr_word[0];
        loop_q.dac_loop <= loop_wr_word[1];
      end
      for (int n = 0; n < N_CH; n++) begin
        if (wr_ch_sel[n]) begin
          chan_cfg_q[n].level <= ch_wr_word[n][DAC_W-1:0];
          chan_cfg_q[n].fb_en <= ch_wr_word[n][CH_FB_BIT];
        end
      end
    end
  end

  ////////////////////
  // responses
  ////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_acc)                     bvalid_q <= 1'b1;
      else if (axil_req_i.bready)     bvalid_q <= 1'b0;  // held until taken
      if (rd_acc)                     rvalid_q <= 1'b1;
      else if (axil_req_i.rready)     rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (wr_acc) begin
      bresp_q <= wr_hit ? RESP_OKAY : RESP_SLVERR;  // id write still okay
    end
    if (rd_acc) begin
      rresp_q <= rd_hit ? RESP_OKAY : RESP_SLVERR;
      rdata_q <= rd_word(axil_req_i.araddr);
    end
  end

  always_comb begin
    axil_rsp_o         = '0;
    axil_rsp_o.awready = wr_acc;  // single cycle pulse
    axil_rsp_o.wready  = wr_acc;
    axil_rsp_o.bvalid  = bvalid_q;
    axil_rsp_o.bresp   = bresp_q;
    axil_rsp_o.arready = rd_acc;
    axil_rsp_o.rvalid  = rvalid_q;
    axil_rsp_o.rdata   = rdata_q;
    axil_rsp_o.rresp   = rresp_q;
  end

  assign loop_o     = loop_q;
  assign chan_cfg_o = chan_cfg_q;

endmodule : housekeeping_regs

`default_nettype wire

// ==== hw/rp_analog_top.sv ====
// analog datapath top
// adc front end, per channel mixers, dac formatter and the housekeeping registers
`timescale 1ns/1ps
`default_nettype none

module rp_analog_top
  import rp_analog_pkg::*;
(
  input  wire logic                       adc_clk,
  input  wire logic                       rst_n_i,
  input  wire logic [N_CH-1:0][ADC_W-1:0] adc_raw_i,     // raw adc lanes
  input  wire axil_req_t                  s_axil_req_i,  // config bus
  output axil_rsp_t                       s_axil_rsp_o,
  output logic [N_CH-1:0][DAC_W-1:0]      dac_code_o     // dac lane n from channel n
);

  loop_cfg_t              loop_cfg;  // both digital loops
  chan_cfg_t [N_CH-1:0]   chan_cfg;
  adc_sample_t [N_CH-1:0] adc_conv;  // converted lanes for the dac loop
  adc_sample_t [N_CH-1:0] adc_dat;   // selected sample per channel
  dac_sample_t [N_CH-1:0] mix;       // registered mixer outputs

  ////////////////////
  // registers
  ////////////////////

  housekeeping_regs u_hk (
    .adc_clk    (adc_clk     ),
    .rst_n_i    (rst_n_i     ),
    .axil_req_i (s_axil_req_i),
    .axil_rsp_o (s_axil_rsp_o),
    .loop_o     (loop_cfg    ),
    .chan_cfg_o (chan_cfg    )
  );

  ////////////////////
  // adc side
  ////////////////////

  adc_frontend u_adc (
    .adc_clk    (adc_clk  ),
    .rst_n_i    (rst_n_i  ),
    .adc_raw_i  (adc_raw_i),
    .loop_i     (loop_cfg ),
    .mix_i      (mix      ),  // adc loop source
    .adc_conv_o (adc_conv ),
    .adc_dat_o  (adc_dat  )
  );

  ////////////////////
  // channel mixers
  ////////////////////

  for (genvar g = 0; g < N_CH; g++) begin : g_mix
    dac_chan_mix u_mix (
      .adc_clk   (adc_clk    ),
      .rst_n_i   (rst_n_i    ),
      .cfg_i     (chan_cfg[g]),
      .adc_dat_i (adc_dat[g] ),
      .mix_o     (mix[g]     )
    );
  end : g_mix

  ////////////////////
  // dac side
  ////////////////////

  dac_formatter u_dac (
    .adc_clk    (adc_clk   ),
    .rst_n_i    (rst_n_i   ),
    .loop_i     (loop_cfg  ),
    .mix_i      (mix       ),
    .adc_conv_i (adc_conv  ),  // dac loop source
    .dac_code_o (dac_code_o)
  );

endmodule : rp_analog_top

`default_nettype wire

// ==== tests/rp_analog_checker.sv ====
// datapath checker
// shadows register writes seen on the bus and models the 3 stage pipeline per cycle
`timescale 1ns/1ps
`default_nettype none

module rp_analog_checker
  import rp_analog_pkg::*;
(
  input  wire logic                       adc_clk,
  input  wire logic                       rst_n_i,
  input  wire logic [N_CH-1:0][ADC_W-1:0] adc_raw_i,
  input  wire axil_req_t                  req_i,
  input  wire axil_rsp_t                  rsp_i,
  input  wire logic [N_CH-1:0][DAC_W-1:0] dac_code_i,
  output int                              err_cnt_o
);

  logic [AXI_DW-1:0] loop_w;         // shadow loop word
  logic [AXI_DW-1:0] ch_w [N_CH];    // shadow channel words
  int                conv_m [N_CH];  // front end, converted lane
  int                dat_m [N_CH];   // front end, selected sample
  int                mix_m [N_CH];   // mix register
  logic [DAC_W-1:0]  code_m [N_CH];  // formatter register
  int                edges;          // edges since reset release
  int                errs = 0;

  // negative-slope code to signed, msb kept
  function automatic int lane_value(input logic [ADC_W-1:0] raw);
    logic signed [ADC_W-1:0] s;
    s = raw ^ 16'h7FFF;
    return s;
  endfunction

  function automatic logic [DAC_W-1:0] dac_code(input int v);
    logic [DAC_W-1:0] b;
    b = v[DAC_W-1:0];
    return b ^ 14'h1FFF;  // lower 13 flipped
  endfunction

  function automatic int clamp14(input int v);
    if (v > 8191) return 8191;
    if (v < -8192) return -8192;
    return v;
  endfunction

  function automatic int level_of(input logic [AXI_DW-1:0] w);
    logic signed [DAC_W-1:0] l;
    l = w[DAC_W-1:0];
    return l;
  endfunction

  function automatic logic [AXI_DW-1:0] strb_merge(input logic [AXI_DW-1:0] old_w,
                                                   input logic [AXI_DW-1:0] new_w,
                                                   input logic [3:0]        strb);
    logic [AXI_DW-1:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  ////////////////////
  // cycle model
  ////////////////////

  // everything sampled at the falling edge, one model step per rising edge
  always @(negedge adc_clk or negedge rst_n_i) begin
    int up;
    int fb;
    int nxt_conv;
    if (!rst_n_i) begin
      loop_w = '0;
      edges  = 0;
      for (int ch = 0; ch < N_CH; ch++) begin
        ch_w[ch]   = '0;
        conv_m[ch] = 0;
        dat_m[ch]  = 0;
        mix_m[ch]  = 0;
        code_m[ch] = 14'h1FFF;  // sample zero
      end
    end else begin
      for (int ch = 0; ch < N_CH; ch++) begin
        if (edges >= 3 && dac_code_i[ch] !== code_m[ch]) begin
          errs++;
          $display("Error at %0t: lane %0d shows %h, expected %h",
                   $time, ch, dac_code_i[ch], code_m[ch]);
        end
      end
      edges++;
      for (int ch = 0; ch < N_CH; ch++) begin
        up         = conv_m[ch] >>> 2;  // upper 14 bits
        code_m[ch] = loop_w[1] ? up[DAC_W-1:0] : dac_code(mix_m[ch]);
        fb         = ch_w[ch][CH_FB_BIT] ? (dat_m[ch] >>> 2) : 0;
        nxt_conv   = lane_value(adc_raw_i[ch]);
        dat_m[ch]  = loop_w[0] ? mix_m[ch] * 4 : nxt_conv;  // old mix into adc loop
        mix_m[ch]  = clamp14(level_of(ch_w[ch]) + fb);
        conv_m[ch] = nxt_conv;
      end
      // accepted write takes effect from the next edge
      if (req_i.awvalid && req_i.wvalid && rsp_i.awready) begin
        if (req_i.awaddr == REG_LOOP) begin
          loop_w = strb_merge(loop_w, req_i.wdata, req_i.wstrb);
        end
        for (int n = 0; n < N_CH; n++) begin
          if (req_i.awaddr == AXI_AW'(REG_CH_BASE + 4 * n)) begin
            ch_w[n] = strb_merge(ch_w[n], req_i.wdata, req_i.wstrb);
          end
        end
      end
    end
  end

  assign err_cnt_o = errs;

endmodule : rp_analog_checker

`default_nettype wire

// ==== tests/tb_rp_analog.sv ====
// analog datapath testbench
// table of register steps with random adc words, bus read-back and a pipeline checker
`timescale 1ns/1ps
`default_nettype none

module tb_rp_analog
  import rp_analog_pkg::*;
();

  localparam int TMO     = 50;   // cycles per handshake wait
  localparam int N_STEPS = 10;
  localparam int AWREADY = 0;
  localparam int BVALID  = 1;
  localparam int ARREADY = 2;
  localparam int RVALID  = 3;

  typedef struct packed {
    logic              en;
    logic [AXI_AW-1:0] addr;
    logic [AXI_DW-1:0] data;
    logic [3:0]        strb;
  } wr_op_t;

  typedef struct packed {
    wr_op_t [0:2]      wr;       // done in order
    logic [3:0]        hold;     // bready low after wr[0], wr[1] presented meanwhile
    logic [7:0]        cycles;   // random adc cycles
    logic              rd_en;
    logic [AXI_AW-1:0] rd_addr;
    logic [AXI_DW-1:0] rd_exp;
    logic [1:0]        rd_resp;
  } step_t;

  localparam wr_op_t NO_WR = '0;

  logic                       adc_clk = 1'b0;
  logic                       rst_n_i;
  logic [N_CH-1:0][ADC_W-1:0] adc_raw;
  axil_req_t                  req;
  axil_rsp_t                  rsp;
  logic [N_CH-1:0][DAC_W-1:0] dac_code;
  int                         chk_errs;
  int                         bus_errs;
  logic [31:0]                lfsr;
  step_t                      steps [N_STEPS];

  always #2 adc_clk = ~adc_clk;  // 4 ns

  rp_analog_top UUT (
    .adc_clk      (adc_clk ),
    .rst_n_i      (rst_n_i ),
    .adc_raw_i    (adc_raw ),
    .s_axil_req_i (req     ),
    .s_axil_rsp_o (rsp     ),
    .dac_code_o   (dac_code)
  );

  rp_analog_checker u_chk (
    .adc_clk    (adc_clk ),
    .rst_n_i    (rst_n_i ),
    .adc_raw_i  (adc_raw ),
    .req_i      (req     ),
    .rsp_i      (rsp     ),
    .dac_code_i (dac_code),
    .err_cnt_o  (chk_errs)
  );

  function automatic wr_op_t reg_wr(input logic [7:0] a, input logic [31:0] d,
                                    input logic [3:0] s);
    return '{1'b1, a, d, s};
  endfunction

  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [15:0] next_adc_word();
    logic [15:0] w;
    for (int b = 0; b < 16; b++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      w[b] = lfsr[0];
    end
    return w;
  endfunction

  function automatic logic [1:0] exp_bresp(input logic [7:0] a);
    if (a == REG_ID || a == REG_LOOP) return RESP_OKAY;
    if (a >= REG_CH_BASE && a < REG_CH_BASE + 4 * N_CH && a[1:0] == 2'b00) return RESP_OKAY;
    return RESP_SLVERR;
  endfunction

  function automatic logic rsp_bit(input int idx);
    case (idx)
      AWREADY: return rsp.awready;
      BVALID:  return rsp.bvalid;
      ARREADY: return rsp.arready;
      default: return rsp.rvalid;
    endcase
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("checker errors %0d, bus errors %0d", chk_errs, bus_errs);
    $display("Errors found");
    $finish;
  endtask

  task automatic wait_rsp(input int idx, input string what);
    int n;
    n = 0;
    do begin
      @(negedge adc_clk);
      n++;
    end while (!rsp_bit(idx) && n < TMO);
    if (!rsp_bit(idx)) abort_run({"Timeout: the ", what, " handshake never completed"});
  endtask

  // wready pulses together with awready
  task automatic confirm_wready();
    if (rsp.wready !== 1'b1) begin
      bus_errs++;
      $display("Error at %0t: wready %b while awready high", $time, rsp.wready);
    end
  endtask

  task automatic present_wr(input wr_op_t op, input logic rdy);
    req.awvalid <= 1'b1;
    req.awaddr  <= op.addr;
    req.wvalid  <= 1'b1;
    req.wdata   <= op.data;
    req.wstrb   <= op.strb;
    req.bready  <= rdy;
  endtask

  task automatic check_bresp(input wr_op_t op);
    if (rsp.bresp !== exp_bresp(op.addr)) begin
      bus_errs++;
      $display("Error at %0t: write to %h got bresp %b", $time, op.addr, rsp.bresp);
    end
  endtask

  task automatic axi_write(input wr_op_t op);
    @(posedge adc_clk);
    present_wr(op, 1'b1);
    wait_rsp(AWREADY, "write address");
    confirm_wready();
    @(posedge adc_clk);
    req.awvalid <= 1'b0;
    req.wvalid  <= 1'b0;
    wait_rsp(BVALID, "write response");
    check_bresp(op);
  endtask

  // first write left unacknowledged while the second one waits
  task automatic stalled_write(input wr_op_t first, input wr_op_t second, input int hold);
    @(posedge adc_clk);
    present_wr(first, 1'b0);
    wait_rsp(AWREADY, "write address");
    confirm_wready();
    @(posedge adc_clk);
    present_wr(second, 1'b0);
    for (int i = 0; i < hold; i++) begin
      @(negedge adc_clk);
      if (!rsp.bvalid || rsp.awready || rsp.wready) begin
        bus_errs++;
        $display("Error at %0t: bvalid %b awready %b wready %b while bready low",
                 $time, rsp.bvalid, rsp.awready, rsp.wready);
      end
    end
    check_bresp(first);
    @(posedge adc_clk);
    req.bready <= 1'b1;
  endtask

  task automatic axi_read(input logic [7:0] a, input logic [31:0] exp, input logic [1:0] resp);
    @(posedge adc_clk);
    req.arvalid <= 1'b1;
    req.araddr  <= a;
    req.rready  <= 1'b1;
    wait_rsp(ARREADY, "read address");
    @(posedge adc_clk);
    req.arvalid <= 1'b0;
    wait_rsp(RVALID, "read data");
    if (rsp.rdata !== exp || rsp.rresp !== resp) begin
      bus_errs++;
      $display("Error at %0t: read %h got %h/%b, expected %h/%b",
               $time, a, rsp.rdata, rsp.rresp, exp, resp);
    end
  endtask

  task automatic run_step(input step_t s);
    for (int k = 0; k < 3; k++) begin
      if (k == 0 && s.wr[0].en && s.hold != 0) stalled_write(s.wr[0], s.wr[1], int'(s.hold));
      else if (s.wr[k].en) axi_write(s.wr[k]);
    end
    for (int k = 0; k < int'(s.cycles); k++) begin
      @(posedge adc_clk);
      adc_raw[0] <= next_adc_word();
      adc_raw[1] <= next_adc_word();
    end
    if (s.rd_en) axi_read(s.rd_addr, s.rd_exp, s.rd_resp);
  endtask

  task automatic fill_table();
    steps[0] = '{'{NO_WR, NO_WR, NO_WR}, 4'd0, 8'd5, 1'b1, REG_ID, ID_VALUE, RESP_OKAY};
    steps[1] = '{'{NO_WR, NO_WR, NO_WR}, 4'd0, 8'd5, 1'b1, 8'h08, 32'h0, RESP_SLVERR};
    // feedback only, level zero
    steps[2] = '{'{reg_wr(8'h10, 32'h0001_0000, 4'hF), reg_wr(8'h14, 32'h0001_0000, 4'hF),
                   NO_WR}, 4'd0, 8'd40, 1'b1, 8'h10, 32'h0001_0000, RESP_OKAY};
    steps[3] = '{'{reg_wr(8'h10, 32'h0000_1FFF, 4'hF), reg_wr(8'h14, 32'h0000_2000, 4'hF),
                   NO_WR}, 4'd0, 8'd10, 1'b1, 8'h14, 32'h0000_2000, RESP_OKAY};
    steps[4] = '{'{reg_wr(8'h10, 32'h0001_1000, 4'hF), reg_wr(8'h14, 32'h0001_3000, 4'hF),
                   NO_WR}, 4'd0, 8'd60, 1'b1, 8'h10, 32'h0001_1000, RESP_OKAY};
    // byte 0 only on ch1, byte 2 only on ch0
    steps[5] = '{'{reg_wr(8'h14, 32'hFFFF_0A55, 4'h1), reg_wr(8'h10, 32'h0000_0000, 4'h4),
                   NO_WR}, 4'd0, 8'd20, 1'b1, 8'h14, 32'h0001_3055, RESP_OKAY};
    steps[6] = '{'{reg_wr(REG_ID, 32'hFFFF_FFFF, 4'hF), reg_wr(8'h40, 32'hFFFF_FFFF, 4'hF),
                   NO_WR}, 4'd0, 8'd10, 1'b1, 8'h10, 32'h0000_1000, RESP_OKAY};
    steps[7] = '{'{reg_wr(REG_LOOP, 32'h2, 4'hF), NO_WR, NO_WR}, 4'd0, 8'd30,
                 1'b1, REG_LOOP, 32'h2, RESP_OKAY};
    // adc loop, levels 1000 and -600
    steps[8] = '{'{reg_wr(REG_LOOP, 32'h1, 4'hF), reg_wr(8'h10, 32'h0001_03E8, 4'hF),
                   reg_wr(8'h14, 32'h0001_3DA8, 4'hF)}, 4'd0, 8'd60, 1'b1, REG_LOOP, 32'h1,
                 RESP_OKAY};
    steps[9] = '{'{reg_wr(8'h10, 32'h0, 4'hF), reg_wr(8'h14, 32'h0, 4'hF),
                   reg_wr(REG_LOOP, 32'h0, 4'hF)}, 4'd6, 8'd20, 1'b1, 8'h14, 32'h0, RESP_OKAY};
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    rst_n_i  = 1'b0;
    adc_raw  = '0;
    req      = '0;
    bus_errs = 0;
    lfsr     = 32'h9ac671c1;
    fill_table();
    repeat (10) @(posedge adc_clk);
    rst_n_i <= 1'b1;
    repeat (3) @(posedge adc_clk);  // reset codes seen by the checker
    for (int i = 0; i < N_STEPS; i++) begin
      run_step(steps[i]);
    end
    repeat (5) @(posedge adc_clk);
    @(negedge adc_clk);
    $display("checker errors %0d, bus errors %0d", chk_errs, bus_errs);
    if (chk_errs == 0 && bus_errs == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule : tb_rp_analog

`default_nettype wire

// ==== rp_analog.f ====
hw/rp_analog_pkg.sv
hw/adc_frontend.sv
hw/dac_chan_mix.sv
hw/dac_formatter.sv
hw/housekeeping_regs.sv
hw/rp_analog_top.sv
tests/rp_analog_checker.sv
tests/tb_rp_analog.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the analog datapath testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module tb_rp_analog \
  -Mdir obj_dir \
  -f rp_analog.f

out=$(./obj_dir/Vtb_rp_analog)
echo "$out"

if echo "$out" | grep -qx "No errors"; then
  exit 0
else
  exit 1
fi
